// File: Makefile
# Verilator flow for the bit-serial core, run from the project root

VERILATOR  ?= verilator
TOP        ?= coreBench
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Finished with no errors
VFLAGS     ?= --timing
LINT_FLAGS ?= --lint-only

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# the log decides pass or fail
sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/coreBenchRef.svh
`ifndef COREBENCHREF_SVH
`define COREBENCHREF_SVH

// shadow copy of the sixteen register slots
logic [insnWidth-1:0] shadowRegs [0:15];

// expected rd and value of one instruction, shadow copy updated
function automatic void refExecute(input logic [insnWidth-1:0] insn,
        output logic [regIdxWidth-1:0] rd, output logic [insnWidth-1:0] value);
    logic [insnWidth-1:0] a;
    logic [insnWidth-1:0] b;
    logic                 isReg;
    rd = insn[10:7];
    isReg = insn[5];
    a = shadowRegs[insn[18:15]];
    // register form takes rs2, immediate form the sign extended imm
    b = isReg ? shadowRegs[insn[23:20]] : {{20{insn[31]}}, insn[31:20]};
    if (insn[6:0] == 7'b0110111) begin
        // upper 20 bits, low 12 zero
        value = {insn[31:12], 12'h000};
    end else begin
        case (insn[14:12])
            3'b000: value = (isReg && insn[30]) ? a - b : a + b;
            3'b100: value = a ^ b;
            3'b110: value = a | b;
            3'b111: value = a & b;
            default: value = 'x;
        endcase
    end
    shadowRegs[rd] = value;
endfunction

task automatic compareWord(input string testName, input logic [insnWidth-1:0] expected,
        input logic [insnWidth-1:0] actual);
    if (actual !== expected) begin
        abortRun($sformatf("[FAIL] %s expected %08h actual %08h", testName, expected, actual));
    end
endtask

task automatic compareAddr(input string testName, input logic [addrWidth-1:0] expected,
        input logic [addrWidth-1:0] actual);
    if (actual !== expected) begin
        abortRun($sformatf("[FAIL] %s address expected %04h actual %04h", testName,
                           expected, actual));
    end
endtask

`endif

// File: bench/coreBench.sv
`timescale 1ns/1ps

module coreBench;
    import rvSerialPkg::*;

    // cycles allowed for any single memory access to complete
    localparam int accessTimeout = 200;
    localparam int randomCount = 20;

    logic     cpuSignals;
    logic     rst;
    memReq_t  memReq;
    memResp_t memResp;

    // whole byte address space
    logic [7:0]           mem [0:(1<<addrWidth)-1];
    logic [insnWidth-1:0] progWords[$];
    string                progNames[$];
    // finished accesses, oldest first
    memReq_t              accessLog[$];

    riscvCore #(.resetPc(resetPcDefault)) UUT (
        .cpuSignals(cpuSignals), .rst(rst), .memReq(memReq), .memResp(memResp)
    );

    always #50 cpuSignals = ~cpuSignals;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1);
    endtask

    `include "coreBenchRef.svh"

    function automatic logic [31:0] encodeRegOp(input logic [6:0] funct7,
            input logic [3:0] rs2, input logic [3:0] rs1, input logic [2:0] funct3,
            input logic [3:0] rd);
        return {funct7, 1'b0, rs2, 1'b0, rs1, funct3, 1'b0, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encodeImmOp(input logic [11:0] imm,
            input logic [3:0] rs1, input logic [2:0] funct3, input logic [3:0] rd);
        return {imm, 1'b0, rs1, funct3, 1'b0, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] encodeLui(input logic [19:0] imm, input logic [3:0] rd);
        return {imm, 1'b0, rd, 7'b0110111};
    endfunction

    // register slot base, four bytes per register
    function automatic logic [addrWidth-1:0] slotAddress(input logic [regIdxWidth-1:0] idx);
        return addrWidth'(idx) * addrWidth'(4);
    endfunction

    task automatic addInsn(input string name, input logic [insnWidth-1:0] word);
        progNames.push_back(name);
        progWords.push_back(word);
    endtask

    task automatic buildProgram();
        int         i;
        int         op;
        logic [3:0] rd;
        logic [3:0] rs1;
        logic [3:0] rs2;
        logic [11:0] imm;
        logic [2:0] funct3;
        addInsn("LUI x1", encodeLui(20'hABCDE, 4'd1));
        addInsn("LUI x2 zero", encodeLui(20'h00000, 4'd2));
        // x2 becomes all ones
        addInsn("ADDI x2 minus one", encodeImmOp(12'hFFF, 4'd2, 3'b000, 4'd2));
        addInsn("LUI x3 zero", encodeLui(20'h00000, 4'd3));
        addInsn("ADDI x3 one", encodeImmOp(12'h001, 4'd3, 3'b000, 4'd3));
        // all ones plus one wraps to zero
        addInsn("ADD wrap", encodeRegOp(7'h00, 4'd3, 4'd2, 3'b000, 4'd4));
        addInsn("SUB wrap", encodeRegOp(7'h20, 4'd2, 4'd3, 3'b000, 4'd5));
        addInsn("LUI x8", encodeLui(20'h00FF0, 4'd8));
        addInsn("ADDI x8 low byte", encodeImmOp(12'h0FF, 4'd8, 3'b000, 4'd8));
        // carry ripples from byte 0 into byte 1
        addInsn("ADD byte carry", encodeRegOp(7'h00, 4'd3, 4'd8, 3'b000, 4'd9));
        addInsn("SUB borrow", encodeRegOp(7'h20, 4'd3, 4'd4, 3'b000, 4'd10));
        addInsn("ADDI negative", encodeImmOp(12'h800, 4'd1, 3'b000, 4'd11));
        addInsn("XORI negative", encodeImmOp(12'hF0F, 4'd1, 3'b100, 4'd12));
        addInsn("ORI", encodeImmOp(12'h123, 4'd8, 3'b110, 4'd13));
        addInsn("ANDI", encodeImmOp(12'h7F0, 4'd1, 3'b111, 4'd14));
        addInsn("AND", encodeRegOp(7'h00, 4'd1, 4'd8, 3'b111, 4'd15));
        addInsn("OR", encodeRegOp(7'h00, 4'd9, 4'd1, 3'b110, 4'd6));
        addInsn("XOR", encodeRegOp(7'h00, 4'd2, 4'd1, 3'b100, 4'd7));
        // x0 is an ordinary slot
        addInsn("ADD into x0", encodeRegOp(7'h00, 4'd2, 4'd1, 3'b000, 4'd0));
        addInsn("LUI x0", encodeLui(20'h12345, 4'd0));
        for (i = 0; i < randomCount; i++) begin
            op = $urandom % 5;
            rd = 4'($urandom);
            rs1 = 4'($urandom);
            rs2 = 4'($urandom);
            imm = 12'($urandom);
            case (op)
                0, 1: funct3 = 3'b000;
                2: funct3 = 3'b111;
                3: funct3 = 3'b110;
                default: funct3 = 3'b100;
            endcase
            // SUB has no immediate form
            if ($urandom % 2 == 1 && op != 1) begin
                addInsn($sformatf("random imm %0d", i), encodeImmOp(imm, rs1, funct3, rd));
            end else begin
                addInsn($sformatf("random reg %0d", i),
                        encodeRegOp(op == 1 ? 7'h20 : 7'h00, rs2, rs1, funct3, rd));
            end
        end
    endtask

    task automatic initMemory();
        int a;
        int r;
        int b;
        // background pattern from the full address
        for (a = 0; a < (1 << addrWidth); a++) begin
            mem[addrWidth'(a)] = 8'(a) ^ 8'(a >> 8) ^ 8'h3C;
        end
        // random register slots, mirrored into the shadow copy
        for (r = 0; r < 16; r++) begin
            for (b = 0; b < 4; b++) begin
                mem[addrWidth'(4 * r + b)] = 8'($urandom);
                shadowRegs[r][8*b +: 8] = mem[addrWidth'(4 * r + b)];
            end
        end
    endtask

    task automatic loadProgram();
        int i;
        int b;
        for (i = 0; i < progWords.size(); i++) begin
            for (b = 0; b < 4; b++) begin
                mem[resetPcDefault + addrWidth'(4 * i + b)] = progWords[i][8*b +: 8];
            end
        end
    endtask

    // memory model, ready after 0 to 3 cycles
    task automatic serveMemory();
        logic    busy;
        int      waitLeft;
        memReq_t acc;
        busy = 1'b0;
        waitLeft = 0;
        forever begin
            @(posedge cpuSignals);
            #1;
            memResp.ready = 1'b0;
            if (!busy && memReq.strobe) begin
                busy = 1'b1;
                waitLeft = $urandom % 4;
            end
            if (busy) begin
                if (waitLeft == 0) begin
                    acc = memReq;
                    if (acc.writeEnable) begin
                        mem[acc.address] = acc.dataWrite;
                    end else begin
                        memResp.dataRead = mem[acc.address];
                    end
                    memResp.ready = 1'b1;
                    accessLog.push_back(acc);
                    busy = 1'b0;
                end else begin
                    waitLeft--;
                end
            end
        end
    endtask

    task automatic nextAccess(output memReq_t acc);
        int waited;
        waited = 0;
        while (accessLog.size() == 0) begin
            if (waited == accessTimeout) begin
                abortRun("timeout: the core made no memory access within the cycle limit");
            end
            @(posedge cpuSignals);
            waited++;
        end
        acc = accessLog.pop_front();
    endtask

    task automatic expectAccess(input string testName, input logic write,
            input logic [addrWidth-1:0] address, output memReq_t acc);
        nextAccess(acc);
        if (acc.writeEnable !== write) begin
            abortRun($sformatf("%s: the core made a %s where a %s was due", testName,
                               acc.writeEnable ? "write" : "read", write ? "write" : "read"));
        end
        compareAddr(testName, address, acc.address);
    endtask

    task automatic expectSlotReads(input string testName, input logic [regIdxWidth-1:0] idx);
        int      b;
        memReq_t acc;
        for (b = 0; b < 4; b++) begin
            expectAccess({testName, " operand"}, 1'b0, slotAddress(idx) + addrWidth'(b), acc);
        end
    endtask

    // checker, walks the access stream instruction by instruction
    task automatic checkProgram();
        int                     i;
        int                     b;
        memReq_t                acc;
        logic [insnWidth-1:0]   word;
        logic [insnWidth-1:0]   expected;
        logic [insnWidth-1:0]   stored;
        logic [regIdxWidth-1:0] rd;
        for (i = 0; i < progWords.size(); i++) begin
            word = progWords[i];
            for (b = 0; b < 4; b++) begin
                expectAccess({progNames[i], " fetch"}, 1'b0,
                             resetPcDefault + addrWidth'(4 * i + b), acc);
            end
            // rs2 first for register ops, then rs1
            if (word[6:0] != 7'b0110111) begin
                if (word[5]) begin
                    expectSlotReads(progNames[i], word[23:20]);
                end
                expectSlotReads(progNames[i], word[18:15]);
            end
            refExecute(word, rd, expected);
            // four writes, low byte first
            for (b = 0; b < 4; b++) begin
                expectAccess({progNames[i], " store"}, 1'b1, slotAddress(rd) + addrWidth'(b), acc);
                stored[8*b +: 8] = acc.dataWrite;
            end
            compareWord(progNames[i], expected, stored);
        end
    endtask

    initial begin
        void'($urandom(32'h9bb3));
        cpuSignals = 1'b0;
        rst = 1'b1;
        memResp = '0;
        initMemory();
        buildProgram();
        loadProgram();
        fork
            serveMemory();
        join_none
        repeat (2) @(posedge cpuSignals);
        #1;
        rst = 1'b0;
        checkProgram();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: hw/coreSequencer.sv
`timescale 1ns/1ps

module coreSequencer #(
    parameter logic [rvSerialPkg::addrWidth-1:0] resetPc = rvSerialPkg::resetPcDefault
) (
    input  logic                              cpuSignals,
    input  logic                              rst,
    input  rvSerialPkg::decodedInsn_t         decoded,
    input  rvSerialPkg::shiftStatus_t         status,
    input  rvSerialPkg::memResp_t             memResp,
    output logic [rvSerialPkg::insnWidth-1:0] insnWord,
    output rvSerialPkg::shiftCtrl_t           shiftCtrl,
    output rvSerialPkg::memReq_t              memReq
);
    import rvSerialPkg::*;

    typedef enum logic [1:0] {
        stFetch,
        stFetched,
        stRegFetch,
        stRegStore
    } seqState_t;

    seqState_t            state;
    logic [addrWidth-1:0] pc;
    // instruction bytes, little endian
    logic [insnWidth-1:0] insnBuf;
    logic [addrWidth-1:0] memAddr;
    logic                 memStrobe;
    logic                 memWriteEnable;
    // one cycle pulse, restarts the shifter after a byte
    logic                 shiftStart;
    // second pass, rs1 combined with y through the ALU
    logic                 xFromAlu;
    // first pass, rs2 streamed from x into y
    logic                 yFromX;
    logic                 byteMode;
    logic                 atPause;
    logic                 enterStore;

    // slot of a register in RAM, four bytes each
    function automatic logic [addrWidth-1:0] regSlot(input logic [regIdxWidth-1:0] idx);
        regSlot = addrWidth'({idx, 2'b00});
    endfunction

    assign insnWord = insnBuf;

    assign memReq.address = memAddr;
    // data byte comes from the shifter, merged at the top
    assign memReq.dataWrite = 8'h00;
    assign memReq.writeEnable = memWriteEnable;
    assign memReq.strobe = memStrobe;

    // shifting only in the operand phases
    assign byteMode = (state == stRegFetch) || (state == stRegStore);
    // shifter idle at a byte edge and no access open
    assign atPause = !memStrobe && !shiftStart && status.byteBoundary;
    assign enterStore = (state == stFetched && decoded.isLui) ||
                        (state == stRegFetch && atPause && status.shiftDone && xFromAlu);

    always_comb begin
        // no shifts while a memory access is open
        shiftCtrl.enable = byteMode && !memStrobe &&
                           (shiftStart || !(status.counterZero ||
                                            (byteMode && status.byteBoundary)));
        shiftCtrl.start = shiftStart;
        shiftCtrl.byteMode = byteMode;
        shiftCtrl.xFromAlu = xFromAlu;
        shiftCtrl.yFromAlu = 1'b0;
        shiftCtrl.yFromX = yFromX;
        shiftCtrl.loadByte = (state == stRegFetch) && memStrobe;
        // store writes byte 0 first, then 24 shifts
        shiftCtrl.preload = enterStore ? preloadOneByte : preloadNone;
        shiftCtrl.loadImmToX = (state == stFetched) && decoded.isLui;
        shiftCtrl.loadImmToY = (state == stFetched) && decoded.isAluOp && decoded.isAluImmediate;
        // carry only lives during the ALU pass
        shiftCtrl.carryClear = !xFromAlu;
    end

    always_ff @(posedge cpuSignals) begin
        if (rst) begin
            state <= stFetch;
            pc <= resetPc;
            memStrobe <= 1'b0;
            memWriteEnable <= 1'b0;
            shiftStart <= 1'b0;
            xFromAlu <= 1'b0;
            yFromX <= 1'b0;
        end else begin
            shiftStart <= 1'b0;
            case (state)
                stFetch: begin
                    if (memStrobe && memResp.ready) begin
                        memStrobe <= 1'b0;
                        pc <= pc + addrWidth'(1);
                        insnBuf <= {memResp.dataRead, insnBuf[insnWidth-1:8]};
                        // fourth byte in
                        if (pc[1:0] == 2'b11) begin
                            state <= stFetched;
                        end
                    end else if (!memStrobe) begin
                        memAddr <= pc;
                        memStrobe <= 1'b1;
                    end
                end
                stFetched: begin
                    if (decoded.isLui) begin
                        // immediate already in x, store right away
                        memAddr <= regSlot(decoded.rdIdx);
                        memWriteEnable <= 1'b1;
                        memStrobe <= 1'b1;
                        state <= stRegStore;
                    end else if (decoded.isAluOp) begin
                        if (decoded.isAluImmediate) begin
                            // y holds the immediate, go for rs1
                            memAddr <= regSlot(decoded.rs1Idx);
                            xFromAlu <= 1'b1;
                        end else begin
                            memAddr <= regSlot(decoded.rs2Idx);
                            yFromX <= 1'b1;
                        end
                        memStrobe <= 1'b1;
                        state <= stRegFetch;
                    end else begin
                        // outside the subset, skip it
                        state <= stFetch;
                    end
                end
                stRegFetch: begin
                    if (memStrobe && memResp.ready) begin
                        memStrobe <= 1'b0;
                        shiftStart <= 1'b1;
                    end else if (atPause) begin
                        if (!status.shiftDone) begin
                            memAddr <= memAddr + addrWidth'(1);
                            memStrobe <= 1'b1;
                        end else if (xFromAlu) begin
                            // result complete in x
                            xFromAlu <= 1'b0;
                            memAddr <= regSlot(decoded.rdIdx);
                            memWriteEnable <= 1'b1;
                            memStrobe <= 1'b1;
                            state <= stRegStore;
                        end else begin
                            // rs2 in y, now rs1 through the ALU
                            yFromX <= 1'b0;
                            xFromAlu <= 1'b1;
                            memAddr <= regSlot(decoded.rs1Idx);
                            memStrobe <= 1'b1;
                        end
                    end
                end
                stRegStore: begin
                    if (memStrobe && memResp.ready) begin
                        memStrobe <= 1'b0;
                        if (status.shiftDone) begin
                            // last byte written, next instruction
                            memWriteEnable <= 1'b0;
                            state <= stFetch;
                        end else begin
                            shiftStart <= 1'b1;
                        end
                    end else if (atPause) begin
                        memAddr <= memAddr + addrWidth'(1);
                        memStrobe <= 1'b1;
                    end
                end
                default: begin
                    state <= stFetch;
                end
            endcase
        end
    end

endmodule

// File: hw/insnDecoder.sv
`timescale 1ns/1ps

module insnDecoder (
    input  logic [rvSerialPkg::insnWidth-1:0] insnWord,
    output rvSerialPkg::decodedInsn_t         decoded
);
    import rvSerialPkg::*;

    // full 7 bit opcodes, 32 bit encodings only
    localparam logic [6:0] opcodeLui = 7'b0110111;
    localparam logic [6:0] opcodeAluImm = 7'b0010011;
    localparam logic [6:0] opcodeAluReg = 7'b0110011;

    logic [6:0] opcode;
    logic       takeBit30;

    assign opcode = insnWord[6:0];

    // low four bits of each register field
    assign decoded.rs1Idx = insnWord[18:15];
    assign decoded.rs2Idx = insnWord[23:20];
    assign decoded.rdIdx = insnWord[10:7];

    assign decoded.isLui = opcode == opcodeLui;
    assign decoded.isAluOp = (opcode == opcodeAluImm) || (opcode == opcodeAluReg);
    // bit 5 clear means rs1 op immediate
    assign decoded.isAluImmediate = !opcode[5];

    // bit 30 belongs to the immediate except for register ops and SRAI
    assign takeBit30 = (opcode[5] || insnWord[14:12] == 3'b101) && insnWord[30];

    // non ALU instructions run the datapath as plain ADD
    assign decoded.aluOp = decoded.isAluOp ? aluOp_t'({takeBit30, insnWord[14:12]}) : opAdd;

    always_comb begin
        if (opcode == opcodeAluImm) begin
            // I-type, sign extended from bit 31
            decoded.immediate = {{20{insnWord[31]}}, insnWord[31:20]};
        end else if (opcode == opcodeLui) begin
            // U-type, low 12 bits zero
            decoded.immediate = {insnWord[31:12], 12'h000};
        end else begin
            decoded.immediate = '0;
        end
    end

endmodule

// File: hw/operandShifter.sv
`timescale 1ns/1ps

module operandShifter (
    input  logic                              cpuSignals,
    input  logic                              rst,
    input  rvSerialPkg::shiftCtrl_t           ctrl,
    input  rvSerialPkg::memResp_t             memResp,
    input  logic [rvSerialPkg::insnWidth-1:0] immediate,
    input  logic                              aluResult,
    input  logic                              aluCarry,
    output logic                              xLsb,
    output logic                              yLsb,
    output logic [7:0]                        wrByte,
    output rvSerialPkg::shiftStatus_t         status
);
    import rvSerialPkg::*;

    // the two working registers, both shift right
    logic [insnWidth-1:0] x;
    logic [insnWidth-1:0] y;
    // counts shifted bits, wraps to zero after 32
    logic [4:0]           shiftCounter;
    logic                 doShift;
    logic                 pausePoint;

    assign status.counterZero = shiftCounter == 5'd0;
    assign status.byteBoundary = shiftCounter[2:0] == 3'd0;
    // a pending start means the run is not over yet
    assign status.shiftDone = status.counterZero && !ctrl.start;

    // stop at zero, or at every byte in byte mode
    assign pausePoint = status.counterZero || (ctrl.byteMode && status.byteBoundary);
    assign doShift = ctrl.enable && (ctrl.start || !pausePoint);

    assign xLsb = x[0];
    assign yLsb = y[0];
    // low byte of x goes out on writes
    assign wrByte = x[7:0];

    always_ff @(posedge cpuSignals) begin
        if (rst) begin
            shiftCounter <= 5'd0;
        end else if (doShift) begin
            shiftCounter <= shiftCounter + 5'd1;
        end else if (ctrl.preload != preloadNone) begin
            shiftCounter <= {ctrl.preload, 3'b000};
        end
    end

    always_ff @(posedge cpuSignals) begin
        if (ctrl.loadImmToX) begin
            x <= immediate;
        end else if (doShift) begin
            // result bit or plain rotate
            x <= {ctrl.xFromAlu ? aluResult : x[0], x[insnWidth-1:1]};
        end else if (ctrl.loadByte && memResp.ready) begin
            // next operand byte lands under the shifted bits
            x[7:0] <= memResp.dataRead;
        end
    end

    always_ff @(posedge cpuSignals) begin
        if (ctrl.loadImmToY) begin
            y <= immediate;
        end else if (doShift) begin
            if (ctrl.yFromAlu) begin
                // y top bit takes the carry chain
                y <= {aluCarry, y[insnWidth-1:1]};
            end else if (ctrl.yFromX) begin
                // operand streamed in from x
                y <= {x[0], y[insnWidth-1:1]};
            end else begin
                y <= {y[0], y[insnWidth-1:1]};
            end
        end
    end

endmodule

// File: hw/riscvCore.sv
`timescale 1ns/1ps

module riscvCore #(
    parameter logic [rvSerialPkg::addrWidth-1:0] resetPc = rvSerialPkg::resetPcDefault
) (
    input  logic                  cpuSignals,
    input  logic                  rst,
    output rvSerialPkg::memReq_t  memReq,
    input  rvSerialPkg::memResp_t memResp
);
    import rvSerialPkg::*;

    decodedInsn_t         decoded;
    shiftCtrl_t           shiftCtrl;
    shiftStatus_t         shiftStatus;
    memReq_t              seqReq;
    logic [insnWidth-1:0] insnWord;
    logic                 xLsb;
    logic                 yLsb;
    logic                 aluResult;
    logic                 aluCarry;
    logic [7:0]           wrByte;

    // write data always from x low byte
    always_comb begin
        memReq = seqReq;
        memReq.dataWrite = wrByte;
    end

    coreSequencer #(.resetPc(resetPc)) seq (
        .cpuSignals(cpuSignals), .rst(rst), .decoded(decoded), .status(shiftStatus),
        .memResp(memResp), .insnWord(insnWord), .shiftCtrl(shiftCtrl), .memReq(seqReq)
    );

    insnDecoder dec (.insnWord(insnWord), .decoded(decoded));

    operandShifter shifter (
        .cpuSignals(cpuSignals), .rst(rst), .ctrl(shiftCtrl), .memResp(memResp),
        .immediate(decoded.immediate), .aluResult(aluResult), .aluCarry(aluCarry),
        .xLsb(xLsb), .yLsb(yLsb), .wrByte(wrByte), .status(shiftStatus)
    );

    // carry steps with every shift
    serialAlu alu (
        .cpuSignals(cpuSignals), .rst(rst), .op(decoded.aluOp), .xBit(xLsb), .yBit(yLsb),
        .step(shiftCtrl.enable), .carryClear(shiftCtrl.carryClear), .result(aluResult),
        .carryOut(aluCarry)
    );

endmodule

// File: hw/rvSerialPkg.sv
package rvSerialPkg;

    // byte address bus width
    localparam int addrWidth = 16;
    // instruction and register word width
    localparam int insnWidth = 32;
    // sixteen general registers
    localparam int regIdxWidth = 4;
    // first fetch address after reset
    localparam logic [addrWidth-1:0] resetPcDefault = 'h2000;

    // shift counter preload, counter bits 4..3
    localparam logic [1:0] preloadNone = 2'b00;
    // skip one byte, leaves 24 shifts for a store
    localparam logic [1:0] preloadOneByte = 2'b01;

    // funct7 bit 30 and funct3 straight from the opcode
    typedef enum logic [3:0] {
        opAdd = 4'b0000,
        opSub = 4'b1000,
        opXor = 4'b0100,
        opOr  = 4'b0110,
        opAnd = 4'b0111
    } aluOp_t;

    // core to memory, held until ready
    typedef struct packed {
        logic [addrWidth-1:0] address;
        logic [7:0]           dataWrite;
        logic                 writeEnable;
        logic                 strobe;
    } memReq_t;

    // memory to core, ready is a single cycle pulse
    typedef struct packed {
        logic [7:0] dataRead;
        logic       ready;
    } memResp_t;

    typedef struct packed {
        logic                   isLui;
        logic                   isAluOp;
        logic                   isAluImmediate;
        aluOp_t                 aluOp;
        logic [regIdxWidth-1:0] rs1Idx;
        logic [regIdxWidth-1:0] rs2Idx;
        logic [regIdxWidth-1:0] rdIdx;
        logic [insnWidth-1:0]   immediate;
    } decodedInsn_t;

    // sequencer to shifter
    typedef struct packed {
        logic       enable;
        logic       start;
        logic       byteMode;
        logic       xFromAlu;
        logic       yFromAlu;
        logic       yFromX;
        logic       loadByte;
        logic [1:0] preload;
        logic       loadImmToX;
        logic       loadImmToY;
        logic       carryClear;
    } shiftCtrl_t;

    // shifter to sequencer
    typedef struct packed {
        logic counterZero;
        logic byteBoundary;
        logic shiftDone;
    } shiftStatus_t;

endpackage

// File: hw/serialAlu.sv
`timescale 1ns/1ps

module serialAlu (
    input  logic                cpuSignals,
    input  logic                rst,
    input  rvSerialPkg::aluOp_t op,
    input  logic                xBit,
    input  logic                yBit,
    input  logic                step,
    input  logic                carryClear,
    output logic                result,
    output logic                carryOut
);
    import rvSerialPkg::*;

    // running carry for add, borrow for sub
    logic carry;

    always_comb begin
        case (op)
            opAdd: begin
                result = xBit ^ yBit ^ carry;
                carryOut = (xBit & yBit) | (carry & (xBit ^ yBit));
            end
            opSub: begin
                // x - y - borrow, same sum bit as add
                result = xBit ^ yBit ^ carry;
                carryOut = (~xBit & yBit) | (carry & ~(xBit ^ yBit));
            end
            opAnd: begin
                result = xBit & yBit;
                carryOut = 1'b0;
            end
            opOr: begin
                result = xBit | yBit;
                carryOut = 1'b0;
            end
            opXor: begin
                result = xBit ^ yBit;
                carryOut = 1'b0;
            end
            default: begin
                result = 1'b0;
                carryOut = 1'b0;
            end
        endcase
    end

    // clear wins over step
    always_ff @(posedge cpuSignals) begin
        if (rst || carryClear) begin
            carry <= 1'b0;
        end else if (step) begin
            carry <= carryOut;
        end
    end

endmodule

// File: sources.f
+incdir+bench
hw/rvSerialPkg.sv
hw/insnDecoder.sv
hw/serialAlu.sv
hw/operandShifter.sv
hw/coreSequencer.sv
hw/riscvCore.sv
bench/coreBench.sv
